//--- dbg_ctl_pkg.sv
//--------------------------------------------------------------------
// Shared types and bit positions for the debug control registers
// Widths and positions are fixed by the debug architecture
// At most one register select bit is set in any cycle
//--------------------------------------------------------------------
package dbg_ctl_pkg;

   typedef logic [31:0] word_t;      // Bus word, write and read data
   typedef logic [3:0]  dbg_sel_t;   // [3] DFSR [2] DHCSR [1] DCRSR [0] DEMCR

   localparam logic [15:0] DHCSR_KEY = 16'hA05F;   // Upper half of DHCSR writes

   // DHCSR bit positions
   localparam int C_DEBUGEN   = 0;
   localparam int C_HALT      = 1;
   localparam int C_STEP      = 2;
   localparam int C_MASKINTS  = 3;
   localparam int S_REGRDY    = 16;
   localparam int S_HALT      = 17;
   localparam int S_SLEEP     = 18;
   localparam int S_LOCKUP    = 19;
   localparam int S_RETIRE_ST = 24;
   localparam int S_RESET_ST  = 25;

   // DFSR bit positions
   localparam int HALTED   = 0;
   localparam int BKPT     = 1;
   localparam int DWTTRAP  = 2;
   localparam int VCATCH   = 3;
   localparam int EXTERNAL = 4;

   // DEMCR bit positions
   localparam int VC_CORERESET = 0;
   localparam int VC_HARDERR   = 10;
   localparam int DWTENA       = 24;

   typedef struct packed {
      logic dfsr_wr;
      logic dhcsr_wr;    // Key already checked
      logic dcrsr_wr;
      logic demcr_wr;
      logic dhcsr_rd;
   } ppb_wr_t;

   typedef struct packed {
      logic ex_last;     // Instruction retiring
      logic ex_reset;    // Core in reset
      logic lockup;
      logic ex_idle;     // Sleeping
      logic int_taken;
      logic int_return;
      logic hardfault;   // Running in HardFault
      logic bpu_event;   // Breakpoint hit
      logic dwt_event;   // Watchpoint hit
   } core_evt_t;

   // One-cycle halt causes, halt control to fault status
   typedef struct packed {
      logic halted_event;
      logic bkpt;
      logic dwt;
      logic vc;
      logic ext;
   } halt_cause_t;

   typedef enum logic {
      RS_RESTARTED,      // Handshake complete
      RS_PENDING         // Restart seen, waiting for release
   } restart_st_t;

endpackage

//--- dbg_reg_decode.sv
//--------------------------------------------------------------------
// Peripheral bus decode for the debug control registers
// DHCSR writes need DHCSR_KEY in the upper half of the write data
//--------------------------------------------------------------------
`timescale 1ns/1ps

module dbg_reg_decode
   import dbg_ctl_pkg::*;
(
   input  logic     dclk,
   input  logic     dbg_reset_n,
   input  dbg_sel_t sel_i,     // One-hot register select
   input  logic     write_i,   // Select is for a write
   input  word_t    wdata_i,
   output ppb_wr_t  ppb_o
);

   logic key_ok;   // Magic key present

   assign key_ok = (wdata_i[31:16] == DHCSR_KEY);

   assign ppb_o.dfsr_wr  = sel_i[3] & write_i;
   assign ppb_o.dhcsr_wr = sel_i[2] & write_i & key_ok;   // Unkeyed writes ignored
   assign ppb_o.dcrsr_wr = sel_i[1] & write_i;
   assign ppb_o.demcr_wr = sel_i[0] & write_i;
   assign ppb_o.dhcsr_rd = sel_i[2] & ~write_i;           // Clears sticky status

   // Upstream decoder never selects two registers at once
   a_sel_onehot: assert property (@(posedge dclk) disable iff (!dbg_reset_n)
      $onehot0(sel_i))
      else $error("debug register selects not one-hot: %b", sel_i);

endmodule

//--- dbg_halt_ctl.sv
//--------------------------------------------------------------------
// DHCSR control bits, halt events, restart handshake, DCRSR run
// C_HALT, the restart flag and the run strobe only move with hready_i
// C_STEP and C_MASKINTS come out of reset set, masked by C_DEBUGEN
//--------------------------------------------------------------------
`timescale 1ns/1ps

module dbg_halt_ctl
   import dbg_ctl_pkg::*;
(
   input  logic        dclk,
   input  logic        dbg_reset_n,
   input  ppb_wr_t     ppb_i,
   input  word_t       wdata_i,
   input  core_evt_t   evt_i,
   input  logic        hready_i,        // Core advance
   input  logic        halt_ack_i,      // Core has halted
   input  logic        restart_req_i,   // CoreSight restart request
   input  logic        ext_req_i,       // External halt request
   input  logic        vc_event_i,      // Vector catch from DEMCR
   output halt_cause_t cause_o,
   output logic        c_debugen_o,
   output logic        c_halt_o,
   output logic        c_step_o,
   output logic        c_maskints_o,
   output logic        s_halt_o,
   output logic        restarted_o,
   output logic        op_run_o
);

   logic        c_debugen_q;
   logic        c_halt_q;        // Raw, before debug enable mask
   logic        c_step_q;
   logic        c_maskints_q;
   logic        op_run_q;
   restart_st_t restart_st;

   logic c_halt;
   logic s_halt;
   logic i_adv;                 // Step advance
   logic step_event;
   logic ext_event;
   logic wr_halt;               // Write carries C_HALT and C_DEBUGEN
   logic halted_event;
   logic set_c_halt;
   logic clr_c_halt;
   logic restarted;
   logic set_restarted;
   logic clr_restarted;

   //-------------------------------------------------------------------
   // Event detection
   //-------------------------------------------------------------------
   assign c_halt = c_debugen_q & c_halt_q;
   assign s_halt = halt_ack_i & c_halt;   // Never set once C_HALT drops

   // Retire, exception entry or exit, lockup
   assign i_adv = evt_i.ex_last | evt_i.int_taken | evt_i.int_return | evt_i.lockup;

   assign step_event   = c_debugen_q & c_step_q & ~c_halt & i_adv & hready_i;
   assign ext_event    = c_debugen_q & ext_req_i & ~s_halt;   // Only while running
   assign wr_halt      = wdata_i[C_HALT] & wdata_i[C_DEBUGEN];
   assign halted_event = (ppb_i.dhcsr_wr & wr_halt) | step_event;

   assign set_c_halt = halted_event | evt_i.bpu_event | evt_i.dwt_event
                     | vc_event_i | ext_event;
   assign clr_c_halt = (ppb_i.dhcsr_wr & ~wr_halt) | set_restarted | evt_i.ex_reset;

   //-------------------------------------------------------------------
   // Restart handshake
   //-------------------------------------------------------------------
   assign restarted     = (restart_st == RS_RESTARTED);
   assign clr_restarted = restart_req_i & s_halt;       // Request while halted
   assign set_restarted = ~restart_req_i & ~restarted;  // Request released

   always_ff @(posedge dclk or negedge dbg_reset_n)
   begin
      if (!dbg_reset_n)
         restart_st <= RS_RESTARTED;
      else if (hready_i && set_restarted)
         restart_st <= RS_RESTARTED;
      else if (hready_i && clr_restarted)
         restart_st <= RS_PENDING;
   end

   //-------------------------------------------------------------------
   // DHCSR control state
   //-------------------------------------------------------------------
   // Any set cause wins over a clear
   always_ff @(posedge dclk or negedge dbg_reset_n)
   begin
      if (!dbg_reset_n)
         c_halt_q <= 1'b0;
      else if (hready_i && (set_c_halt || clr_c_halt))
         c_halt_q <= set_c_halt;
   end

   always_ff @(posedge dclk or negedge dbg_reset_n)
   begin
      if (!dbg_reset_n)
      begin
         c_debugen_q  <= 1'b0;
         c_step_q     <= 1'b1;
         c_maskints_q <= 1'b1;
      end
      else if (ppb_i.dhcsr_wr)
      begin
         c_debugen_q  <= wdata_i[C_DEBUGEN];
         c_step_q     <= wdata_i[C_STEP];
         c_maskints_q <= wdata_i[C_MASKINTS];
      end
   end

   // Core register access strobe, one hready cycle wide
   always_ff @(posedge dclk or negedge dbg_reset_n)
   begin
      if (!dbg_reset_n)
         op_run_q <= 1'b0;
      else if (hready_i)
         op_run_q <= s_halt & ppb_i.dcrsr_wr;
   end

   assign cause_o.halted_event = halted_event;
   assign cause_o.bkpt         = evt_i.bpu_event;
   assign cause_o.dwt          = evt_i.dwt_event;
   assign cause_o.vc           = vc_event_i;
   assign cause_o.ext          = ext_event;

   assign c_debugen_o  = c_debugen_q;
   assign c_halt_o     = c_halt;
   assign c_step_o     = c_debugen_q & c_step_q;
   assign c_maskints_o = c_debugen_q & c_maskints_q;
   assign s_halt_o     = s_halt;
   assign restarted_o  = restarted;
   assign op_run_o     = op_run_q;

endmodule

//--- dbg_fault_status.sv
//--------------------------------------------------------------------
// DFSR sticky halt-cause bits, write one to clear
// A cause in the same cycle as its clear keeps the bit set
//--------------------------------------------------------------------
`timescale 1ns/1ps

module dbg_fault_status
   import dbg_ctl_pkg::*;
(
   input  logic        dclk,
   input  logic        dbg_reset_n,
   input  ppb_wr_t     ppb_i,
   input  word_t       wdata_i,
   input  halt_cause_t cause_i,
   input  logic        hready_i,
   input  logic        dwt_event_i,   // Raw watchpoint hit
   output logic [4:0]  dfsr_o
);

   logic [4:0] dfsr_q;
   logic [4:0] cause_v;   // Value loaded on update
   logic [4:0] upd_v;     // Per-bit update enable

   always_comb
   begin
      cause_v[HALTED]   = cause_i.halted_event;
      cause_v[BKPT]     = cause_i.bkpt;
      cause_v[DWTTRAP]  = cause_i.dwt;
      cause_v[VCATCH]   = cause_i.vc;
      cause_v[EXTERNAL] = cause_i.ext;
      upd_v = cause_v | ({5{ppb_i.dfsr_wr}} & wdata_i[4:0]);
      // Watchpoint only counts on a core advance
      upd_v[DWTTRAP] = (hready_i & dwt_event_i) | (ppb_i.dfsr_wr & wdata_i[DWTTRAP]);
   end

   always_ff @(posedge dclk or negedge dbg_reset_n)
   begin
      if (!dbg_reset_n)
         dfsr_q <= '0;
      else
         dfsr_q <= (dfsr_q & ~upd_v) | (cause_v & upd_v);
   end

   assign dfsr_o = dfsr_q;

endmodule

//--- dbg_demcr.sv
//--------------------------------------------------------------------
// DEMCR watchpoint enable and vector catch bits
// Vector catch only fires with C_DEBUGEN set
//--------------------------------------------------------------------
`timescale 1ns/1ps

module dbg_demcr
   import dbg_ctl_pkg::*;
(
   input  logic      dclk,
   input  logic      dbg_reset_n,
   input  ppb_wr_t   ppb_i,
   input  word_t     wdata_i,
   input  core_evt_t evt_i,
   input  logic      c_debugen_i,
   output logic      dwt_ena_o,    // DWTENA, unmasked
   output logic      vc_flt_o,     // VC_HARDERR
   output logic      vc_rst_o,     // VC_CORERESET
   output logic      vc_event_o
);

   logic vc_rst_trig;
   logic vc_flt_trig;

   always_ff @(posedge dclk or negedge dbg_reset_n)
   begin
      if (!dbg_reset_n)
      begin
         dwt_ena_o <= 1'b0;
         vc_flt_o  <= 1'b0;
         vc_rst_o  <= 1'b0;
      end
      else if (ppb_i.demcr_wr)
      begin
         dwt_ena_o <= wdata_i[DWTENA];
         vc_flt_o  <= wdata_i[VC_HARDERR];
         vc_rst_o  <= wdata_i[VC_CORERESET];
      end
   end

   assign vc_rst_trig = vc_rst_o & evt_i.ex_reset;
   assign vc_flt_trig = vc_flt_o & evt_i.int_taken & evt_i.hardfault;   // HardFault entry
   assign vc_event_o  = c_debugen_i & (vc_rst_trig | vc_flt_trig);

endmodule

//--- dbg_status_read.sv
//--------------------------------------------------------------------
// Sticky retire and reset status, register read-data assembly
// Read data is combinational on the select, DCRSR reads zero
// S_RESET_ST comes out of reset set
//--------------------------------------------------------------------
`timescale 1ns/1ps

module dbg_status_read
   import dbg_ctl_pkg::*;
(
   input  logic       dclk,
   input  logic       dbg_reset_n,
   input  ppb_wr_t    ppb_i,
   input  core_evt_t  evt_i,
   input  dbg_sel_t   sel_i,
   input  logic       c_debugen_i,
   input  logic       c_halt_i,
   input  logic       c_step_i,
   input  logic       c_maskints_i,
   input  logic       s_halt_i,
   input  logic [4:0] dfsr_i,
   input  logic       dwt_ena_i,
   input  logic       vc_flt_i,
   input  logic       vc_rst_i,
   output word_t      rdata_o
);

   logic  s_retire_st;
   logic  s_reset_st;
   logic  i_ret;          // Retire or lockup
   word_t dhcsr;
   word_t dfsr;
   word_t demcr;

   assign i_ret = evt_i.ex_last | evt_i.lockup;

   //-------------------------------------------------------------------
   // Sticky status, cleared by a DHCSR read
   //-------------------------------------------------------------------
   always_ff @(posedge dclk or negedge dbg_reset_n)
   begin
      if (!dbg_reset_n)
      begin
         s_retire_st <= 1'b0;
         s_reset_st  <= 1'b1;
      end
      else
      begin
         if (ppb_i.dhcsr_rd || i_ret || evt_i.ex_reset)
            s_retire_st <= i_ret;            // Core reset clears too
         if (ppb_i.dhcsr_rd || evt_i.ex_reset)
            s_reset_st <= evt_i.ex_reset;
      end
   end

   //-------------------------------------------------------------------
   // Register images
   //-------------------------------------------------------------------
   always_comb
   begin
      dhcsr              = '0;
      dhcsr[C_DEBUGEN]   = c_debugen_i;
      dhcsr[C_HALT]      = c_halt_i;
      dhcsr[C_STEP]      = c_step_i;
      dhcsr[C_MASKINTS]  = c_maskints_i;
      dhcsr[S_REGRDY]    = s_halt_i;       // Accesses resolve in one hready cycle
      dhcsr[S_HALT]      = s_halt_i;
      dhcsr[S_SLEEP]     = evt_i.ex_idle;
      dhcsr[S_LOCKUP]    = evt_i.lockup;
      dhcsr[S_RETIRE_ST] = s_retire_st;
      dhcsr[S_RESET_ST]  = s_reset_st;

      dfsr        = '0;
      dfsr[4:0]   = dfsr_i;                // HALTED through EXTERNAL

      demcr               = '0;
      demcr[VC_CORERESET] = vc_rst_i;
      demcr[VC_HARDERR]   = vc_flt_i;
      demcr[DWTENA]       = dwt_ena_i;
   end

   assign rdata_o = ({32{sel_i[3]}} & dfsr)
                  | ({32{sel_i[2]}} & dhcsr)
                  | ({32{sel_i[0]}} & demcr);

endmodule

//--- dbg_ctl.sv
//--------------------------------------------------------------------
// Debug control and status register block, top level
// Debug is always present, one register select bus, no arbitration
//--------------------------------------------------------------------
`timescale 1ns/1ps

module dbg_ctl
   import dbg_ctl_pkg::*;
(
   input  logic     dclk,
   input  logic     dbg_reset_n,
   input  dbg_sel_t sel_i,
   input  logic     write_i,
   input  word_t    wdata_i,
   input  logic     hready_i,
   input  logic     halt_ack_i,
   input  logic     restart_req_i,
   input  logic     ext_req_i,
   input  logic     ex_last_i,
   input  logic     ex_reset_i,
   input  logic     lockup_i,
   input  logic     ex_idle_i,
   input  logic     int_taken_i,
   input  logic     int_return_i,
   input  logic     hardfault_i,
   input  logic     bpu_event_i,
   input  logic     dwt_event_i,
   output word_t    rdata_o,
   output logic     halt_req_o,
   output logic     s_halt_o,
   output logic     c_debugen_o,
   output logic     c_maskints_o,
   output logic     dwt_en_o,
   output logic     op_run_o,
   output logic     restarted_o
);

   ppb_wr_t     ppb;
   core_evt_t   evt;
   halt_cause_t cause;
   logic        c_step;
   logic [4:0]  dfsr;
   logic        dwt_ena;
   logic        vc_flt;
   logic        vc_rst;
   logic        vc_event;

   assign evt = '{ex_last: ex_last_i, ex_reset: ex_reset_i, lockup: lockup_i,
                  ex_idle: ex_idle_i, int_taken: int_taken_i,
                  int_return: int_return_i, hardfault: hardfault_i,
                  bpu_event: bpu_event_i, dwt_event: dwt_event_i};

   assign dwt_en_o = dwt_ena & c_debugen_o;   // Watchpoints need debug enabled

   dbg_reg_decode u_decode (
      .dclk(dclk), .dbg_reset_n(dbg_reset_n),
      .sel_i(sel_i), .write_i(write_i), .wdata_i(wdata_i), .ppb_o(ppb)
   );

   dbg_halt_ctl u_halt (
      .dclk(dclk), .dbg_reset_n(dbg_reset_n),
      .ppb_i(ppb), .wdata_i(wdata_i), .evt_i(evt), .hready_i(hready_i),
      .halt_ack_i(halt_ack_i), .restart_req_i(restart_req_i),
      .ext_req_i(ext_req_i), .vc_event_i(vc_event), .cause_o(cause),
      .c_debugen_o(c_debugen_o), .c_halt_o(halt_req_o), .c_step_o(c_step),
      .c_maskints_o(c_maskints_o), .s_halt_o(s_halt_o),
      .restarted_o(restarted_o), .op_run_o(op_run_o)
   );

   dbg_fault_status u_dfsr (
      .dclk(dclk), .dbg_reset_n(dbg_reset_n),
      .ppb_i(ppb), .wdata_i(wdata_i), .cause_i(cause), .hready_i(hready_i),
      .dwt_event_i(dwt_event_i), .dfsr_o(dfsr)
   );

   dbg_demcr u_demcr (
      .dclk(dclk), .dbg_reset_n(dbg_reset_n),
      .ppb_i(ppb), .wdata_i(wdata_i), .evt_i(evt), .c_debugen_i(c_debugen_o),
      .dwt_ena_o(dwt_ena), .vc_flt_o(vc_flt), .vc_rst_o(vc_rst),
      .vc_event_o(vc_event)
   );

   dbg_status_read u_read (
      .dclk(dclk), .dbg_reset_n(dbg_reset_n),
      .ppb_i(ppb), .evt_i(evt), .sel_i(sel_i),
      .c_debugen_i(c_debugen_o), .c_halt_i(halt_req_o), .c_step_i(c_step),
      .c_maskints_i(c_maskints_o), .s_halt_i(s_halt_o), .dfsr_i(dfsr),
      .dwt_ena_i(dwt_ena), .vc_flt_i(vc_flt), .vc_rst_i(vc_rst),
      .rdata_o(rdata_o)
   );

endmodule

//--- tb_dbg_ctl.sv
//--------------------------------------------------------------------
// Testbench for the debug control block
// Reference model tracks register state and is compared every cycle
// Inputs change on the rising edge, outputs sampled on the falling edge
// DFSR is only written when no halt cause is active
//--------------------------------------------------------------------
`timescale 1ns/1ps

module tb_dbg_ctl
   import dbg_ctl_pkg::*;
;

   localparam dbg_sel_t SEL_DFSR  = 4'b1000;
   localparam dbg_sel_t SEL_DHCSR = 4'b0100;
   localparam dbg_sel_t SEL_DCRSR = 4'b0010;
   localparam dbg_sel_t SEL_DEMCR = 4'b0001;

   // Event kinds, 0 to 3 match DFSR bit minus one
   localparam int EV_BKPT   = 0;
   localparam int EV_DWT    = 1;
   localparam int EV_RESET  = 2;   // Used as vector catch
   localparam int EV_EXT    = 3;
   localparam int EV_RETIRE = 4;

   localparam int TEST_CYCLES = 160;              // About 145 cycles for all six tests
   localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

   logic     dclk;
   logic     dbg_reset_n;
   dbg_sel_t sel_i;
   logic     write_i;
   word_t    wdata_i;
   logic     hready_i, halt_ack_i, restart_req_i, ext_req_i;
   logic     ex_last_i, ex_reset_i, lockup_i, ex_idle_i;
   logic     int_taken_i, int_return_i, hardfault_i, bpu_event_i, dwt_event_i;
   word_t    rdata_o;
   logic     halt_req_o, s_halt_o, c_debugen_o, c_maskints_o;
   logic     dwt_en_o, op_run_o, restarted_o;

   int chk_cnt   = 0;
   int err_cnt   = 0;
   int err_base  = 0;     // Errors before current test
   int test_num  = 0;
   int cycle_cnt = 0;

   dbg_ctl u_dbg_ctl (
      .dclk(dclk), .dbg_reset_n(dbg_reset_n),
      .sel_i(sel_i), .write_i(write_i), .wdata_i(wdata_i), .hready_i(hready_i),
      .halt_ack_i(halt_ack_i), .restart_req_i(restart_req_i), .ext_req_i(ext_req_i),
      .ex_last_i(ex_last_i), .ex_reset_i(ex_reset_i), .lockup_i(lockup_i),
      .ex_idle_i(ex_idle_i), .int_taken_i(int_taken_i), .int_return_i(int_return_i),
      .hardfault_i(hardfault_i), .bpu_event_i(bpu_event_i), .dwt_event_i(dwt_event_i),
      .rdata_o(rdata_o), .halt_req_o(halt_req_o), .s_halt_o(s_halt_o),
      .c_debugen_o(c_debugen_o), .c_maskints_o(c_maskints_o), .dwt_en_o(dwt_en_o),
      .op_run_o(op_run_o), .restarted_o(restarted_o)
   );

   initial
   begin
      dclk = 1'b0;
      forever #5 dclk = ~dclk;   // 100 MHz
   end

   //-------------------------------------------------------------------
   // Reference model
   //-------------------------------------------------------------------
   logic       m_debugen, m_halt, m_step, m_mask, m_pend, m_oprun;
   logic       m_dwtena, m_vcflt, m_vcrst, m_retire, m_reset;
   logic [4:0] m_dfsr;
   logic       keyed, halt_pair, mc_halt, ms_halt, adv, step_ev, ext_ev;
   logic       halt_ev, vc_ev, rel, m_set, m_clr;
   logic [4:0] m_cause;          // EXTERNAL down to HALTED

   assign keyed     = sel_i[2] & write_i & (wdata_i[31:16] == DHCSR_KEY);
   assign halt_pair = wdata_i[C_HALT] & wdata_i[C_DEBUGEN];
   assign mc_halt   = m_debugen & m_halt;
   assign ms_halt   = halt_ack_i & mc_halt;
   assign adv       = ex_last_i | int_taken_i | int_return_i | lockup_i;
   assign step_ev   = m_debugen & m_step & ~mc_halt & adv & hready_i;
   assign ext_ev    = m_debugen & ext_req_i & ~ms_halt;    // Only while running
   assign halt_ev   = (keyed & halt_pair) | step_ev;
   assign vc_ev     = m_debugen & ((m_vcrst & ex_reset_i)
                    | (m_vcflt & int_taken_i & hardfault_i));
   assign rel       = ~restart_req_i & m_pend;            // Restart released
   assign m_set     = halt_ev | bpu_event_i | dwt_event_i | vc_ev | ext_ev;
   assign m_clr     = (keyed & ~halt_pair) | rel | ex_reset_i;
   assign m_cause   = {ext_ev, vc_ev, hready_i & dwt_event_i, bpu_event_i, halt_ev};

   always @(posedge dclk or negedge dbg_reset_n)
   begin
      if (!dbg_reset_n)
      begin
         m_debugen <= 1'b0;
         m_halt    <= 1'b0;
         m_step    <= 1'b1;
         m_mask    <= 1'b1;
         m_pend    <= 1'b0;
         m_oprun   <= 1'b0;
         m_dfsr    <= '0;
         m_dwtena  <= 1'b0;
         m_vcflt   <= 1'b0;
         m_vcrst   <= 1'b0;
         m_retire  <= 1'b0;
         m_reset   <= 1'b1;
      end
      else
      begin
         if (hready_i && (m_set || m_clr))
            m_halt <= m_set;                  // Set beats clear
         if (hready_i && rel)
            m_pend <= 1'b0;
         else if (hready_i && restart_req_i && ms_halt)
            m_pend <= 1'b1;
         if (hready_i)
            m_oprun <= ms_halt & sel_i[1] & write_i;
         if (keyed)
         begin
            m_debugen <= wdata_i[C_DEBUGEN];
            m_step    <= wdata_i[C_STEP];
            m_mask    <= wdata_i[C_MASKINTS];
         end
         if (sel_i[0] && write_i)
         begin
            m_dwtena <= wdata_i[DWTENA];
            m_vcflt  <= wdata_i[VC_HARDERR];
            m_vcrst  <= wdata_i[VC_CORERESET];
         end
         // Write one clears, a cause keeps it set
         m_dfsr <= m_cause | (m_dfsr & ~((sel_i[3] & write_i) ? wdata_i[4:0] : 5'b0));
         if (ex_last_i || lockup_i)
            m_retire <= 1'b1;
         else if ((sel_i[2] && !write_i) || ex_reset_i)
            m_retire <= 1'b0;
         if (ex_reset_i)
            m_reset <= 1'b1;
         else if (sel_i[2] && !write_i)
            m_reset <= 1'b0;
      end
   end

   // Expected read word for a register select
   function automatic word_t expected_read(input dbg_sel_t sel);
      word_t w;
      w = '0;
      if (sel[2])
      begin
         w[C_DEBUGEN]   = m_debugen;
         w[C_HALT]      = mc_halt;
         w[C_STEP]      = m_debugen & m_step;
         w[C_MASKINTS]  = m_debugen & m_mask;
         w[S_REGRDY]    = ms_halt;
         w[S_HALT]      = ms_halt;
         w[S_SLEEP]     = ex_idle_i;
         w[S_LOCKUP]    = lockup_i;
         w[S_RETIRE_ST] = m_retire;
         w[S_RESET_ST]  = m_reset;
      end
      else if (sel[3])
         w[4:0] = m_dfsr;
      else if (sel[0])
      begin
         w[VC_CORERESET] = m_vcrst;
         w[VC_HARDERR]   = m_vcflt;
         w[DWTENA]       = m_dwtena;
      end
      return w;                              // DCRSR reads zero
   endfunction

   //-------------------------------------------------------------------
   // Checker and compare process
   //-------------------------------------------------------------------
   task automatic check_value(input string name, input word_t actual, input word_t expected);
      chk_cnt++;
      if (actual !== expected)
      begin
         err_cnt++;
         $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   always @(negedge dclk)
   begin
      if (dbg_reset_n)
      begin
         check_value("rdata_o", rdata_o, expected_read(sel_i));
         check_value("halt_req_o", 32'(halt_req_o), 32'(mc_halt));
         check_value("s_halt_o", 32'(s_halt_o), 32'(ms_halt));
         check_value("c_debugen_o", 32'(c_debugen_o), 32'(m_debugen));
         check_value("c_maskints_o", 32'(c_maskints_o), 32'(m_debugen & m_mask));
         check_value("dwt_en_o", 32'(dwt_en_o), 32'(m_dwtena & m_debugen));
         check_value("op_run_o", 32'(op_run_o), 32'(m_oprun));
         check_value("restarted_o", 32'(restarted_o), 32'(!m_pend));
      end
   end

   always @(posedge dclk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("Timeout, stimulus still running after %0d cycles", cycle_cnt);
         $display("TEST FAILED");
         $finish;
      end
   end

   //-------------------------------------------------------------------
   // Stimulus helpers
   //-------------------------------------------------------------------
   task automatic bus_write(input dbg_sel_t sel, input word_t data);
      @(posedge dclk);
      sel_i   <= sel;
      write_i <= 1'b1;
      wdata_i <= data;
      @(posedge dclk);                     // Write lands on this edge
      sel_i   <= '0;
      write_i <= 1'b0;
   endtask

   task automatic bus_read(input dbg_sel_t sel, output word_t data);
      @(posedge dclk);
      sel_i   <= sel;
      write_i <= 1'b0;
      wdata_i <= $urandom;                 // Noise, ignored on reads
      @(negedge dclk);
      data = rdata_o;
      @(posedge dclk);
      sel_i   <= '0;
   endtask

   // One-cycle core event, hready_i as given
   task automatic pulse_event(input int kind, input logic rdy);
      @(posedge dclk);
      hready_i <= rdy;
      case (kind)
         EV_BKPT:  bpu_event_i <= 1'b1;
         EV_DWT:   dwt_event_i <= 1'b1;
         EV_RESET: ex_reset_i  <= 1'b1;
         EV_EXT:   ext_req_i   <= 1'b1;
         default:  ex_last_i   <= 1'b1;
      endcase
      @(posedge dclk);
      hready_i    <= 1'b1;
      bpu_event_i <= 1'b0;
      dwt_event_i <= 1'b0;
      ex_reset_i  <= 1'b0;
      ext_req_i   <= 1'b0;
      ex_last_i   <= 1'b0;
   endtask

   task automatic end_test(input string name);
      test_num++;
      if (err_cnt == err_base)
         $display("test %0d %s: ok", test_num, name);
      else
         $display("test %0d %s: %0d errors", test_num, name, err_cnt - err_base);
      err_base = err_cnt;
   endtask

   //-------------------------------------------------------------------
   // Tests
   //-------------------------------------------------------------------
   initial
   begin
      word_t       rd;
      word_t       mask;
      int          order [4];
      int          k;
      int          tmp;
      logic [1:0]  a;
      logic [1:0]  b;
      tmp = $urandom(87);
      dbg_reset_n <= 1'b0;
      sel_i <= '0;
      write_i <= 1'b0;
      wdata_i <= '0;
      hready_i <= 1'b1;
      halt_ack_i <= 1'b0;
      restart_req_i <= 1'b0;
      ext_req_i <= 1'b0;
      ex_last_i <= 1'b0;
      ex_reset_i <= 1'b0;
      lockup_i <= 1'b0;
      ex_idle_i <= 1'b0;
      int_taken_i <= 1'b0;
      int_return_i <= 1'b0;
      hardfault_i <= 1'b0;
      bpu_event_i <= 1'b0;
      dwt_event_i <= 1'b0;
      repeat (3) @(posedge dclk);
      dbg_reset_n <= 1'b1;

      // Key check
      bus_write(SEL_DHCSR, 32'h0000_000D);  // No key
      @(negedge dclk);
      check_value("c_debugen_o", 32'(c_debugen_o), 32'd0);
      bus_write(SEL_DHCSR, {DHCSR_KEY, 16'h0005});
      bus_read(SEL_DHCSR, rd);
      check_value("dhcsr ctl bits", 32'(rd[3:0]), 32'h5);
      bus_write(SEL_DHCSR, {DHCSR_KEY, 16'h0009});
      bus_read(SEL_DHCSR, rd);
      check_value("dhcsr ctl bits", 32'(rd[3:0]), 32'h9);
      end_test("key check");

      // Halt request and acknowledge
      bus_write(SEL_DHCSR, {DHCSR_KEY, 16'h0003});
      @(negedge dclk);
      check_value("halt_req_o", 32'(halt_req_o), 32'd1);
      @(posedge dclk);
      halt_ack_i <= 1'b1;
      bus_read(SEL_DHCSR, rd);
      check_value("S_HALT", 32'(rd[S_HALT]), 32'd1);
      check_value("S_REGRDY", 32'(rd[S_REGRDY]), 32'd1);
      bus_read(SEL_DFSR, rd);
      check_value("DFSR.HALTED", 32'(rd[HALTED]), 32'd1);
      bus_write(SEL_DHCSR, {DHCSR_KEY, 16'h0001});
      @(negedge dclk);
      check_value("halt_req_o", 32'(halt_req_o), 32'd0);
      @(posedge dclk);
      halt_ack_i <= 1'b0;
      bus_write(SEL_DFSR, 32'h1F);
      end_test("halt and acknowledge");

      // Halt causes in random order
      order[0] = 0;
      order[1] = 1;
      order[2] = 2;
      order[3] = 3;
      for (int i = 3; i > 0; i--)
      begin
         a = 2'(i);
         b = 2'($urandom % (i + 1));
         tmp = order[a];
         order[a] = order[b];
         order[b] = tmp;
      end
      bus_write(SEL_DEMCR, 32'h0000_0001);   // VC_CORERESET for the reset catch
      for (int i = 0; i < 4; i++)
      begin
         a = 2'(i);
         k = order[a];
         mask = word_t'(1) << (k + 1);
         repeat ($urandom % 4) @(posedge dclk);
         pulse_event(k, 1'b1);
         @(negedge dclk);
         check_value("halt_req_o", 32'(halt_req_o), 32'd1);
         bus_read(SEL_DFSR, rd);
         check_value("dfsr cause bit", rd & mask, mask);
         bus_write(SEL_DHCSR, {DHCSR_KEY, 16'h0001});
         bus_write(SEL_DFSR, mask);
         bus_read(SEL_DFSR, rd);
         check_value("dfsr after clear", 32'(rd[4:0]), 32'd0);
      end
      end_test("halt causes");

      // Single step, only with hready_i high
      bus_write(SEL_DHCSR, {DHCSR_KEY, 16'h0005});
      pulse_event(EV_RETIRE, 1'b0);
      @(negedge dclk);
      check_value("halt_req_o", 32'(halt_req_o), 32'd0);
      pulse_event(EV_RETIRE, 1'b1);
      @(negedge dclk);
      check_value("halt_req_o", 32'(halt_req_o), 32'd1);
      bus_write(SEL_DHCSR, {DHCSR_KEY, 16'h0001});
      bus_write(SEL_DFSR, 32'h1F);
      end_test("stepping");

      // Restart handshake
      bus_write(SEL_DHCSR, {DHCSR_KEY, 16'h0003});
      @(posedge dclk);
      halt_ack_i <= 1'b1;
      @(posedge dclk);
      restart_req_i <= 1'b1;
      @(posedge dclk);                      // Restart seen while halted
      @(negedge dclk);
      check_value("restarted_o", 32'(restarted_o), 32'd0);
      @(posedge dclk);
      restart_req_i <= 1'b0;
      @(posedge dclk);                      // Release completes handshake
      @(negedge dclk);
      check_value("restarted_o", 32'(restarted_o), 32'd1);
      check_value("halt_req_o", 32'(halt_req_o), 32'd0);
      @(posedge dclk);
      halt_ack_i <= 1'b0;
      bus_write(SEL_DFSR, 32'h1F);
      end_test("restart handshake");

      // DEMCR, DCRSR and sticky status
      bus_write(SEL_DEMCR, 32'h0100_0000);
      @(negedge dclk);
      check_value("dwt_en_o", 32'(dwt_en_o), 32'd1);
      bus_write(SEL_DHCSR, {DHCSR_KEY, 16'h0000});
      @(negedge dclk);
      check_value("dwt_en_o", 32'(dwt_en_o), 32'd0);
      bus_write(SEL_DHCSR, {DHCSR_KEY, 16'h0003});
      @(posedge dclk);
      halt_ack_i <= 1'b1;
      bus_write(SEL_DCRSR, $urandom);
      @(negedge dclk);
      check_value("op_run_o", 32'(op_run_o), 32'd1);
      @(negedge dclk);
      check_value("op_run_o", 32'(op_run_o), 32'd0);
      bus_write(SEL_DHCSR, {DHCSR_KEY, 16'h0001});
      @(posedge dclk);
      halt_ack_i <= 1'b0;
      bus_write(SEL_DFSR, 32'h1F);
      bus_read(SEL_DEMCR, rd);
      check_value("DEMCR.DWTENA", 32'(rd[DWTENA]), 32'd1);
      pulse_event(EV_RETIRE, 1'b1);
      bus_read(SEL_DHCSR, rd);
      check_value("S_RETIRE_ST", 32'(rd[S_RETIRE_ST]), 32'd1);
      bus_read(SEL_DHCSR, rd);
      check_value("S_RETIRE_ST", 32'(rd[S_RETIRE_ST]), 32'd0);
      pulse_event(EV_RESET, 1'b1);
      bus_read(SEL_DHCSR, rd);
      check_value("S_RESET_ST", 32'(rd[S_RESET_ST]), 32'd1);
      bus_read(SEL_DHCSR, rd);
      check_value("S_RESET_ST", 32'(rd[S_RESET_ST]), 32'd0);
      end_test("demcr, dcrsr and sticky status");

      $display("%0d tests, %0d checks, %0d errors", test_num, chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- dbg_ctl.f
dbg_ctl_pkg.sv
dbg_reg_decode.sv
dbg_halt_ctl.sv
dbg_fault_status.sv
dbg_demcr.sv
dbg_status_read.sv
dbg_ctl.sv
tb_dbg_ctl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the debug control testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_dbg_ctl \
      -f dbg_ctl.f -Mdir obj_dir; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vtb_dbg_ctl)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
   exit 0
fi
exit 1
